// ==== Bender.yml ====
package:
  name: niu32

sources:
  - src/niuPkg.sv
  - src/registerFile.sv
  - src/aluUnit.sv
  - src/dataPath.sv
  - src/controlUnit.sv
  - src/memorySystem.sv
  - src/niuTop.sv
  - target: simulation
    files:
      - sim/niuTb.sv

// ==== sim/niuTb.sv ====
`timescale 1ns/10ps

module niuTb;

    localparam int TimeoutCycles = 3000;

    logic        clk;
    logic        reset;
    logic [9:0]  switches;
    logic [3:0]  keys;
    logic [9:0]  ledr;
    logic [7:0]  ledg;
    logic [15:0] hexValue;

    logic [31:0] lcgState;
    int          checkCount;
    int          errorCount;
    int          testCount;

    niuTop dut (
        .clk      (clk),
        .reset    (reset),
        .switches (switches),
        .keys     (keys),
        .ledr     (ledr),
        .ledg     (ledg),
        .hexValue (hexValue)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [9:0] expectedLedr(input int s, input int k);
        int value;
        value = ((s + k) ^ 'h0F0) * 2;
        return 10'(value % 1024);
    endfunction

    function automatic logic [15:0] expectedHex(input int s, input int k);
        int diff;
        int half;
        diff = s - k;
        half = diff / 2;
        // Odd negative differences need one step below the truncated quotient
        if (diff < 0 && diff % 2 != 0) begin
            half = half - 1;
        end
        return half[15:0];
    endfunction

    function automatic logic [7:0] expectedLedg(input int s, input int k);
        if (s < k) begin
            return 8'h01;
        end else if (s == k) begin
            return 8'h02;
        end
        return 8'h04;
    endfunction

    task automatic driveInputs(input int s, input int k);
        @(posedge clk);
        #10;
        switches = 10'(s);
        keys = 4'(k);
    endtask

    task automatic checkValue(input string testName, input string signalName,
                              input logic [15:0] expected, input logic [15:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("error in %s: %s expected %h, actual %h",
                     testName, signalName, expected, actual);
        end
    endtask

    // Watch bit 0 selects ledr, bit 1 hexValue and bit 2 ledg
    task automatic waitForOutputs(input string testName, input logic [2:0] watch,
                                  input logic [9:0] wantLedr, input logic [15:0] wantHex,
                                  input logic [7:0] wantLedg);
        int   cycles;
        logic matched;
        cycles = 0;
        matched = 1'b0;
        while (!matched && cycles < TimeoutCycles) begin
            @(posedge clk);
            #10;
            cycles++;
            matched = (!watch[0] || ledr === wantLedr)
                   && (!watch[1] || hexValue === wantHex)
                   && (!watch[2] || ledg === wantLedg);
        end
        if (!matched) begin
            errorCount++;
            $display("%s: outputs did not reach the expected values within %0d cycles",
                     testName, TimeoutCycles);
        end
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        testCount++;
        $display("test %s done: %0d errors", testName, errorCount - errorsBefore);
    endtask

    task automatic resetTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #10;
            checkValue("reset", "ledr", 16'h0, ledr);
            checkValue("reset", "ledg", 16'h0, ledg);
            checkValue("reset", "hexValue", 16'h0, hexValue);
        end
        reset = 1'b0;
        // Outputs stay clear until the program's first store
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            #10;
            checkValue("reset", "ledr", 16'h0, ledr);
            checkValue("reset", "ledg", 16'h0, ledg);
            checkValue("reset", "hexValue", 16'h0, hexValue);
        end
        finishTest("reset", errorsBefore);
    endtask

    task automatic arithmeticTest();
        int          errorsBefore;
        logic [31:0] rnd;
        int          s;
        int          k;
        errorsBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            rnd = nextRandom();
            s = rnd[25:16];
            k = rnd[11:8];
            driveInputs(s, k);
            waitForOutputs("arithmetic", 3'b001, expectedLedr(s, k), 16'h0, 8'h0);
            checkValue("arithmetic", "ledr", expectedLedr(s, k), ledr);
        end
        finishTest("arithmetic", errorsBefore);
    endtask

    task automatic signedShiftTest();
        int          errorsBefore;
        logic [31:0] rnd;
        int          sValues [$];
        int          kValues [$];
        int          s;
        int          k;
        errorsBefore = errorCount;
        // Directed pairs come first and include keys above switches
        sValues = '{2, 0, 1000, 7};
        kValues = '{13, 15, 7, 7};
        for (int i = 0; i < 3; i++) begin
            rnd = nextRandom();
            sValues.push_back(rnd[19:16]);
            kValues.push_back(rnd[11:8]);
        end
        foreach (sValues[i]) begin
            s = sValues[i];
            k = kValues[i];
            driveInputs(s, k);
            waitForOutputs("signed shift", 3'b010, 10'h0, expectedHex(s, k), 8'h0);
            checkValue("signed shift", "hexValue", expectedHex(s, k), hexValue);
        end
        finishTest("signed shift", errorsBefore);
    endtask

    task automatic branchTest();
        int errorsBefore;
        int sValues [3];
        int kValues [3];
        errorsBefore = errorCount;
        sValues = '{3, 9, 600};
        kValues = '{9, 9, 9};
        foreach (sValues[i]) begin
            driveInputs(sValues[i], kValues[i]);
            waitForOutputs("branch", 3'b100, 10'h0, 16'h0,
                           expectedLedg(sValues[i], kValues[i]));
            checkValue("branch", "ledg", expectedLedg(sValues[i], kValues[i]), ledg);
        end
        finishTest("branch", errorsBefore);
    endtask

    task automatic loopTest();
        int          errorsBefore;
        logic [31:0] rnd;
        int          s;
        int          k;
        errorsBefore = errorCount;
        for (int i = 0; i < 5; i++) begin
            rnd = nextRandom();
            s = rnd[27:18];
            k = rnd[13:10];
            driveInputs(s, k);
            waitForOutputs("loop", 3'b111, expectedLedr(s, k), expectedHex(s, k),
                           expectedLedg(s, k));
            checkValue("loop", "ledr", expectedLedr(s, k), ledr);
            checkValue("loop", "hexValue", expectedHex(s, k), hexValue);
            checkValue("loop", "ledg", expectedLedg(s, k), ledg);
        end
        finishTest("loop", errorsBefore);
    endtask

    initial begin
        lcgState = 32'd3;
        checkCount = 0;
        errorCount = 0;
        testCount = 0;
        reset = 1'b1;
        switches = '0;
        keys = '0;

        resetTest();
        arithmeticTest();
        signedShiftTest();
        branchTest();
        loopTest();

        $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim/program.hex ====
// One 32-bit instruction word per line in hex, loaded from word address 0
// Fields: op1 31:27, rx 26:22, ry 21:17, low 16:0 (rz 16:12, op2 4:0)
083C0004 // addi r30, r0, 4      loop address
80030120 // lw   r1, switches
80050100 // lw   r2, keys
0000B004 // not  r11, r0
00443001 // add  r3, r1, r2
00D63001 // add  r3, r3, r11
00D63000 // sub  r3, r3, r11
38C800F0 // xori r4, r3, 0xF0
410A0001 // shli r5, r4, 1
980B0020 // sw   r5, ledr
00446000 // sub  r6, r1, r2
598E0001 // srai r7, r6, 1
980E0100 // sw   r7, 0x100(r0)
80100100 // lw   r8, 0x100(r0)
2A12FFFF // andi r9, r8, 0xFFFF
0240A006 // or   r10, r9, r0
98150000 // sw   r10, hex
D0440002 // blt  r1, r2, +2
C0440003 // beq  r1, r2, +3
C8440004 // bne  r1, r2, +4
08180001 // addi r12, r0, 1
C0000003 // beq  r0, r0, +3
08180002 // addi r12, r0, 2
C0000001 // beq  r0, r0, +1
08180004 // addi r12, r0, 4
98190040 // sw   r12, ledg
78000000 // unknown opcode
FFBE0000 // jal  r31, r30

// ==== sources.f ====
src/niuPkg.sv
src/registerFile.sv
src/aluUnit.sv
src/dataPath.sv
src/controlUnit.sv
src/memorySystem.sv
src/niuTop.sv
sim/niuTb.sv

// ==== src/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit import niuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ldA,
    input  logic     ldB,
    input  word_t    bus,
    input  aluFunc_t aluFunc,
    output word_t    result
);

    word_t a;
    word_t b;
    word_t nextResult;

    always_comb begin
        case (aluFunc)
            FuncSub: nextResult = a - b;
            FuncAdd: nextResult = a + b;
            FuncNot: nextResult = ~a;
            FuncAnd: nextResult = a & b;
            FuncOr:  nextResult = a | b;
            FuncXor: nextResult = a ^ b;
            FuncShl: nextResult = a << b[4:0];
            FuncShr: nextResult = a >> b[4:0];
            FuncSra: nextResult = $signed(a) >>> b[4:0];
            // Comparisons are signed and give 0 or 1
            FuncEq:  nextResult = word_t'(a == b);
            FuncNeq: nextResult = word_t'(a != b);
            FuncLt:  nextResult = word_t'($signed(a) < $signed(b));
            FuncLe:  nextResult = word_t'($signed(a) <= $signed(b));
            default: nextResult = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a <= '0;
            b <= '0;
            result <= '0;
        end else begin
            if (ldA) begin
                a <= bus;
            end
            if (ldB) begin
                b <= bus;
            end
            result <= nextResult;
        end
    end

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit import niuPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instr_t instr,
    input  logic   aluTrue,
    output ctrl_t  ctrl
);

    ctrlState_t state;
    ctrlState_t nextState;
    aluFunc_t   opFunc;
    aluFunc_t   branchFunc;
    logic       isRegForm;

    assign isRegForm = (instr.op1 == OpAlu);

    // Immediate forms reuse the secondary opcode codes in op1
    always_comb begin
        if (isRegForm) begin
            opFunc = aluFunc_t'(instr.low[4:0]);
        end else begin
            opFunc = aluFunc_t'(instr.op1);
        end

        case (instr.op1)
            OpBne:   branchFunc = FuncNeq;
            OpBlt:   branchFunc = FuncLt;
            OpBle:   branchFunc = FuncLe;
            default: branchFunc = FuncEq;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= Fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = Fetch;
        case (state)
            Fetch:  nextState = Decode;
            Decode: begin
                case (instr.op1)
                    OpAlu, OpAddi, OpAndi, OpOri, OpXori,
                    OpShli, OpShri, OpSrai:     nextState = AluLoadB;
                    OpLw:                       nextState = LwLoadA;
                    OpSw:                       nextState = SwLoadA;
                    OpBeq, OpBne, OpBlt, OpBle: nextState = BrLoadA;
                    OpJal:                      nextState = JalLink;
                    // Unknown opcode acts as a no-op
                    default:                    nextState = Fetch;
                endcase
            end
            AluLoadB:   nextState = AluLoadA;
            AluLoadA:   nextState = AluCompute;
            AluCompute: nextState = AluWrite;
            LwLoadA:    nextState = LwLoadB;
            LwLoadB:    nextState = LwAdd;
            LwAdd:      nextState = LwMar;
            LwMar:      nextState = LwWait;
            LwWait:     nextState = LwWrite;
            SwLoadA:    nextState = SwLoadB;
            SwLoadB:    nextState = SwAdd;
            SwAdd:      nextState = SwMar;
            SwMar:      nextState = SwWrite;
            BrLoadA:    nextState = BrLoadB;
            BrLoadB:    nextState = BrCompare;
            BrCompare:  nextState = BrTest;
            BrTest:     nextState = aluTrue ? BrOffset : Fetch;
            BrOffset:   nextState = BrAdd;
            BrAdd:      nextState = BrLoadPc;
            JalLink:    nextState = JalJump;
            default:    nextState = Fetch;
        endcase
    end

    always_comb begin
        ctrl = '{busSrc: BusNone, regField: FieldRx, aluFunc: FuncAdd, default: 1'b0};
        case (state)
            Fetch: begin
                ctrl.ldIr = 1'b1;
                ctrl.incPc = 1'b1;
            end
            AluLoadB: begin
                ctrl.busSrc = isRegForm ? BusReg : BusImm;
                ctrl.regField = FieldRy;
                ctrl.ldB = 1'b1;
            end
            AluLoadA, LwLoadA, SwLoadA, BrLoadA: begin
                ctrl.busSrc = BusReg;
                ctrl.regField = FieldRx;
                ctrl.ldA = 1'b1;
            end
            AluCompute: ctrl.aluFunc = opFunc;
            AluWrite: begin
                ctrl.busSrc = BusAlu;
                ctrl.regField = isRegForm ? FieldRz : FieldRy;
                ctrl.aluFunc = opFunc;
                ctrl.wrReg = 1'b1;
            end
            LwLoadB, SwLoadB: begin
                ctrl.busSrc = BusImm;
                ctrl.ldB = 1'b1;
            end
            LwMar, SwMar: begin
                ctrl.busSrc = BusAlu;
                ctrl.ldMar = 1'b1;
            end
            LwWrite: begin
                ctrl.busSrc = BusMdr;
                ctrl.regField = FieldRy;
                ctrl.wrReg = 1'b1;
            end
            SwWrite: begin
                ctrl.busSrc = BusReg;
                ctrl.regField = FieldRy;
                ctrl.wrMem = 1'b1;
            end
            BrLoadB: begin
                ctrl.busSrc = BusReg;
                ctrl.regField = FieldRy;
                ctrl.ldB = 1'b1;
            end
            BrCompare: ctrl.aluFunc = branchFunc;
            // A takes the incremented PC whether or not the branch is taken
            BrTest: begin
                ctrl.busSrc = BusPc;
                ctrl.ldA = 1'b1;
            end
            BrOffset: begin
                ctrl.busSrc = BusImmX4;
                ctrl.ldB = 1'b1;
            end
            BrLoadPc: begin
                ctrl.busSrc = BusAlu;
                ctrl.ldPc = 1'b1;
            end
            JalLink: begin
                ctrl.busSrc = BusPc;
                ctrl.regField = FieldRy;
                ctrl.wrReg = 1'b1;
            end
            JalJump: begin
                ctrl.busSrc = BusReg;
                ctrl.regField = FieldRx;
                ctrl.ldPc = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/dataPath.sv ====
`timescale 1ns/10ps

module dataPath import niuPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  ctrl_t  ctrl,
    input  word_t  imemWord,
    input  word_t  mdr,
    output word_t  bus,
    output word_t  pc,
    output instr_t instr,
    output logic   aluTrue
);

    word_t   immExt;
    word_t   regData;
    word_t   aluResult;
    regIdx_t regSel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= PcStart;
            instr <= '0;
        end else begin
            if (ctrl.ldPc) begin
                pc <= bus;
            end else if (ctrl.incPc) begin
                pc <= pc + WordBytes;
            end
            if (ctrl.ldIr) begin
                instr <= imemWord;
            end
        end
    end

    // Sign-extend the 17-bit immediate
    assign immExt = {{15{instr.low[16]}}, instr.low};

    always_comb begin
        case (ctrl.regField)
            FieldRy: regSel = instr.ry;
            FieldRz: regSel = instr.low[16:12];
            default: regSel = instr.rx;
        endcase
    end

    always_comb begin
        case (ctrl.busSrc)
            BusPc:    bus = pc;
            BusReg:   bus = regData;
            BusMdr:   bus = mdr;
            BusAlu:   bus = aluResult;
            BusImm:   bus = immExt;
            // Branch offsets count instructions
            BusImmX4: bus = immExt << 2;
            default:  bus = '0;
        endcase
    end

    registerFile regs (
        .clk    (clk),
        .reset  (reset),
        .regSel (regSel),
        .wrReg  (ctrl.wrReg),
        .wrData (bus),
        .rdData (regData)
    );

    aluUnit alu (
        .clk     (clk),
        .reset   (reset),
        .ldA     (ctrl.ldA),
        .ldB     (ctrl.ldB),
        .bus     (bus),
        .aluFunc (ctrl.aluFunc),
        .result  (aluResult)
    );

    assign aluTrue = aluResult[0];

endmodule

// ==== src/memorySystem.sv ====
`timescale 1ns/10ps

module memorySystem import niuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrl_t       ctrl,
    input  word_t       pc,
    input  word_t       bus,
    input  logic [9:0]  switches,
    input  logic [3:0]  keys,
    output word_t       imemWord,
    output word_t       mdr,
    output logic [9:0]  ledr,
    output logic [7:0]  ledg,
    output logic [15:0] hexValue
);

    word_t       imem [ImemWords];
    word_t       dmem [DmemWords];
    word_t       mar;
    logic [15:0] hexReg;
    logic [9:0]  ledrReg;
    logic [7:0]  ledgReg;
    memIdx_t     dataIdx;
    logic        isIo;

    initial begin
        $readmemh(ProgramFile, imem);
    end

    assign imemWord = imem[memIdx_t'(pc[12:2])];

    assign dataIdx = mar[12:2];
    assign isIo = (mar == AddrHex) || (mar == AddrLedr) || (mar == AddrLedg);

    always_ff @(posedge clk) begin
        if (ctrl.wrMem && !isIo) begin
            dmem[dataIdx] <= bus;
        end
    end

    // MDR follows MAR with one cycle of latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
            hexReg <= '0;
            ledrReg <= '0;
            ledgReg <= '0;
        end else begin
            if (ctrl.ldMar) begin
                mar <= bus;
            end
            if (mar == AddrKey) begin
                mdr <= word_t'(keys);
            end else if (mar == AddrSwitch) begin
                mdr <= word_t'(switches);
            end else begin
                mdr <= dmem[dataIdx];
            end
            if (ctrl.wrMem) begin
                case (mar)
                    AddrHex:  hexReg <= bus[15:0];
                    AddrLedr: ledrReg <= bus[9:0];
                    AddrLedg: ledgReg <= bus[7:0];
                    default: ;
                endcase
            end
        end
    end

    assign ledr = ledrReg;
    assign ledg = ledgReg;
    assign hexValue = hexReg;

endmodule

// ==== src/niuPkg.sv ====
package niuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [16:0] imm_t;
    typedef logic [10:0] memIdx_t;

    // low holds rz in 16:12 and op2 in 4:0
    typedef struct packed {
        opcode_t op1;
        regIdx_t rx;
        regIdx_t ry;
        imm_t    low;
    } instr_t;

    // Codes match the secondary opcodes
    typedef enum logic [4:0] {
        FuncSub = 5'b00000,
        FuncAdd = 5'b00001,
        FuncNot = 5'b00100,
        FuncAnd = 5'b00101,
        FuncOr  = 5'b00110,
        FuncXor = 5'b00111,
        FuncShl = 5'b01000,
        FuncShr = 5'b01010,
        FuncSra = 5'b01011,
        FuncEq  = 5'b10000,
        FuncNeq = 5'b10001,
        FuncLt  = 5'b10010,
        FuncLe  = 5'b10011
    } aluFunc_t;

    typedef enum logic [2:0] {
        BusNone,
        BusPc,
        BusReg,
        BusMdr,
        BusAlu,
        BusImm,
        BusImmX4
    } busSrc_t;

    typedef enum logic [1:0] {
        FieldRx,
        FieldRy,
        FieldRz
    } regField_t;

    typedef enum logic [4:0] {
        Fetch,
        Decode,
        AluLoadB,
        AluLoadA,
        AluCompute,
        AluWrite,
        LwLoadA,
        LwLoadB,
        LwAdd,
        LwMar,
        LwWait,
        LwWrite,
        SwLoadA,
        SwLoadB,
        SwAdd,
        SwMar,
        SwWrite,
        BrLoadA,
        BrLoadB,
        BrCompare,
        BrTest,
        BrOffset,
        BrAdd,
        BrLoadPc,
        JalLink,
        JalJump
    } ctrlState_t;

    typedef struct packed {
        busSrc_t   busSrc;
        regField_t regField;
        aluFunc_t  aluFunc;
        logic      ldPc;
        logic      incPc;
        logic      ldIr;
        logic      ldMar;
        logic      wrMem;
        logic      wrReg;
        logic      ldA;
        logic      ldB;
    } ctrl_t;

    // Primary opcodes
    localparam opcode_t OpAlu  = 5'b00000;
    localparam opcode_t OpAddi = 5'b00001;
    localparam opcode_t OpAndi = 5'b00101;
    localparam opcode_t OpOri  = 5'b00110;
    localparam opcode_t OpXori = 5'b00111;
    localparam opcode_t OpShli = 5'b01000;
    localparam opcode_t OpShri = 5'b01010;
    localparam opcode_t OpSrai = 5'b01011;
    localparam opcode_t OpLw   = 5'b10000;
    localparam opcode_t OpSw   = 5'b10011;
    localparam opcode_t OpBeq  = 5'b11000;
    localparam opcode_t OpBne  = 5'b11001;
    localparam opcode_t OpBlt  = 5'b11010;
    localparam opcode_t OpBle  = 5'b11011;
    localparam opcode_t OpJal  = 5'b11111;

    localparam int    WordBytes = 4;
    localparam int    ImemWords = 2048;
    localparam int    DmemWords = 2048;
    localparam word_t PcStart   = 32'h0000_0000;

    // Memory-mapped I/O
    localparam word_t AddrHex    = 32'hFFFF_0000;
    localparam word_t AddrLedr   = 32'hFFFF_0020;
    localparam word_t AddrLedg   = 32'hFFFF_0040;
    localparam word_t AddrKey    = 32'hFFFF_0100;
    localparam word_t AddrSwitch = 32'hFFFF_0120;

    localparam string ProgramFile = "program.hex";

endpackage

// ==== src/niuTop.sv ====
`timescale 1ns/10ps

module niuTop import niuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [9:0]  switches,
    input  logic [3:0]  keys,
    output logic [9:0]  ledr,
    output logic [7:0]  ledg,
    output logic [15:0] hexValue
);

    ctrl_t  ctrl;
    instr_t instr;
    logic   aluTrue;
    word_t  bus;
    word_t  pc;
    word_t  imemWord;
    word_t  mdr;

    controlUnit control (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .aluTrue (aluTrue),
        .ctrl    (ctrl)
    );

    dataPath datapath (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .imemWord (imemWord),
        .mdr      (mdr),
        .bus      (bus),
        .pc       (pc),
        .instr    (instr),
        .aluTrue  (aluTrue)
    );

    memorySystem memory (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .pc       (pc),
        .bus      (bus),
        .switches (switches),
        .keys     (keys),
        .imemWord (imemWord),
        .mdr      (mdr),
        .ledr     (ledr),
        .ledg     (ledg),
        .hexValue (hexValue)
    );

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/10ps

module registerFile import niuPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t regSel,
    input  logic    wrReg,
    input  word_t   wrData,
    output word_t   rdData
);

    word_t regs [32];

    // r0 is an ordinary register and is not hardwired
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wrReg) begin
            regs[regSel] <= wrData;
        end
    end

    assign rdData = regs[regSel];

endmodule
